/* src/dds_sine_table.svh */
`ifndef DDS_SINE_TABLE_SVH
`define DDS_SINE_TABLE_SVH

// first quarter of a sine, sampled at half-step offsets
// entry i = round(2047 * sin((i + 0.5) * pi / 128))
// no entry is zero, so mirroring never produces a repeated zero crossing
localparam logic [10:0] sine_quarter [64] = '{
   11'd25,   11'd75,   11'd126,  11'd176,  11'd226,  11'd275,  11'd325,  11'd375,
   11'd424,  11'd473,  11'd522,  11'd570,  11'd618,  11'd666,  11'd713,  11'd760,
   11'd807,  11'd852,  11'd898,  11'd943,  11'd987,  11'd1031, 11'd1074, 11'd1116,
   11'd1158, 11'd1199, 11'd1239, 11'd1279, 11'd1318, 11'd1356, 11'd1393, 11'd1430,
   11'd1465, 11'd1500, 11'd1533, 11'd1566, 11'd1598, 11'd1629, 11'd1659, 11'd1688,
   11'd1716, 11'd1743, 11'd1769, 11'd1793, 11'd1817, 11'd1840, 11'd1861, 11'd1881,
   11'd1901, 11'd1919, 11'd1936, 11'd1951, 11'd1966, 11'd1979, 11'd1992, 11'd2003,
   11'd2012, 11'd2021, 11'd2028, 11'd2035, 11'd2039, 11'd2043, 11'd2046, 11'd2047
};

`endif

/* src/dds_pkg.sv */
`default_nettype none

package dds_pkg;

   //////////////////////////////////////////////////
   // widths
   //////////////////////////////////////////////////
   localparam int PHASE_W    = 32;   // phase accumulator
   localparam int SAMPLE_W   = 12;   // output sample
   localparam int LUT_ADDR_W = 8;    // top phase bits that index one full wave

   typedef logic [PHASE_W-1:0]         phase_t;
   typedef logic signed [SAMPLE_W-1:0] sample_t;  // two's complement
   typedef logic [4:0]                 lfsr_t;
   typedef logic [31:0]                period_t;  // bit period in clk cycles
   typedef logic [1:0]                 select_t;

   // all ones so the sequence starts in a legal state
   localparam lfsr_t LFSR_SEED = '1;

   //////////////////////////////////////////////////
   // selector codes
   //////////////////////////////////////////////////
   // plain carrier waveform, signal_sel
   localparam select_t SIG_SINE   = 2'd0;
   localparam select_t SIG_COSINE = 2'd1;
   localparam select_t SIG_SAW    = 2'd2;
   localparam select_t SIG_SQUARE = 2'd3;

   // keyed output, modulation_sel
   localparam select_t MOD_ASK  = 2'd0;
   localparam select_t MOD_FSK  = 2'd1;
   localparam select_t MOD_BPSK = 2'd2;
   localparam select_t MOD_RAW  = 2'd3;

   // full scale, used by square and raw bit
   localparam sample_t SAMPLE_MAX = 12'sh7ff;
   localparam sample_t SAMPLE_MIN = 12'sh800;

endpackage

`default_nettype wire

/* src/lfsr_bit_source.sv */
`timescale 1ns/10ps
`default_nettype none

// pseudo-random bit stream, one new bit per bit_period clocks
module lfsr_bit_source
   import dds_pkg::*;
(
   input  logic    clk,
   input  logic    reset,
   input  period_t bit_period,
   output logic    data_bit
);

   period_t count;      // clocks into the current bit
   logic    wrap;       // last clock of the period
   logic    bit_tick;   // one-cycle advance strobe
   lfsr_t   lfsr;

   // >= keeps the counter bounded if bit_period shrinks mid-count
   assign wrap = (count >= bit_period - 1'b1);

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         count    <= '0;
         bit_tick <= 1'b0;
      end
      else
      begin
         count    <= wrap ? '0 : count + 1'b1;
         bit_tick <= wrap;
      end
   end

   // fibonacci form, taps 0 and 2
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         lfsr <= LFSR_SEED;
      else if (bit_tick)
         lfsr <= {lfsr[0] ^ lfsr[2], lfsr[4:1]};
   end

   assign data_bit = lfsr[0];

   // all zeros is the lock-up state of this LFSR
   a_lfsr_nonzero: assert property (@(posedge clk) disable iff (reset)
      lfsr != '0);

   // a zero period would stall the counter near its top value
   a_period_valid: assert property (@(posedge clk) disable iff (reset)
      bit_period != '0);

endmodule

`default_nettype wire

/* src/dds_waveform_gen.sv */
`timescale 1ns/10ps
`default_nettype none

// DDS core: phase accumulator with four registered waveforms
module dds_waveform_gen
   import dds_pkg::*;
(
   input  logic    clk,
   input  logic    reset,
   input  phase_t  phase_increment,
   output sample_t sine,
   output sample_t cosine,
   output sample_t saw,
   output sample_t square
);

   `include "dds_sine_table.svh"

   phase_t                phase;
   logic [LUT_ADDR_W-1:0] sine_idx;     // wave index k
   logic [LUT_ADDR_W-1:0] cosine_idx;   // k + quarter wave

   //////////////////////////////////////////////////
   // quarter-wave mirroring
   //////////////////////////////////////////////////
   // bit 7 picks the sign half, bit 6 runs the quarter backwards
   function automatic sample_t wave_lookup(input logic [LUT_ADDR_W-1:0] idx);
      logic [LUT_ADDR_W-3:0] addr;
      sample_t               mag;
      addr = idx[LUT_ADDR_W-2] ? ~idx[LUT_ADDR_W-3:0] : idx[LUT_ADDR_W-3:0];
      mag  = {1'b0, sine_quarter[addr]};
      return idx[LUT_ADDR_W-1] ? -mag : mag;
   endfunction

   assign sine_idx   = phase[PHASE_W-1 -: LUT_ADDR_W];
   assign cosine_idx = sine_idx + {2'b01, {(LUT_ADDR_W-2){1'b0}}};  // wraps mod 256

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         phase <= '0;
      else
         phase <= phase + phase_increment;
   end

   //////////////////////////////////////////////////
   // sample registers, one cycle behind the phase
   //////////////////////////////////////////////////
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         sine   <= '0;
         cosine <= '0;
         saw    <= '0;
         square <= '0;
      end
      else
      begin
         sine   <= wave_lookup(sine_idx);
         cosine <= wave_lookup(cosine_idx);
         saw    <= phase[PHASE_W-1 -: SAMPLE_W];                 // top bits as signed ramp
         square <= phase[PHASE_W-1] ? SAMPLE_MIN : SAMPLE_MAX;   // high in first half
      end
   end

endmodule

`default_nettype wire

/* src/modulation_select.sv */
`timescale 1ns/10ps
`default_nettype none

// keys the carrier with the data bit and picks the two outputs
module modulation_select
   import dds_pkg::*;
(
   input  logic    clk,
   input  logic    reset,
   input  select_t modulation_sel,
   input  select_t signal_sel,
   input  logic    data_bit,
   input  sample_t sine,
   input  sample_t cosine,
   input  sample_t saw,
   input  sample_t square,
   input  sample_t fsk_cosine,
   output sample_t modulation_out,
   output sample_t signal_out,
   output logic    bit_out
);

   sample_t ask_wave;
   sample_t bpsk_wave;
   sample_t raw_wave;
   sample_t keyed;    // selected modulation
   sample_t plain;    // selected carrier waveform

   assign ask_wave  = data_bit ? cosine : '0;        // on-off keying
   assign bpsk_wave = data_bit ? cosine : -cosine;   // table never hits SAMPLE_MIN
   assign raw_wave  = data_bit ? SAMPLE_MAX : SAMPLE_MIN;

   always_comb
   begin
      unique case (modulation_sel)
         MOD_ASK:  keyed = ask_wave;
         MOD_FSK:  keyed = fsk_cosine;   // second generator carries the frequency shift
         MOD_BPSK: keyed = bpsk_wave;
         MOD_RAW:  keyed = raw_wave;
      endcase
   end

   always_comb
   begin
      unique case (signal_sel)
         SIG_SINE:   plain = sine;
         SIG_COSINE: plain = cosine;
         SIG_SAW:    plain = saw;
         SIG_SQUARE: plain = square;
      endcase
   end

   //////////////////////////////////////////////////
   // output stage, bit travels with its sample
   //////////////////////////////////////////////////
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         modulation_out <= '0;
         signal_out     <= '0;
         bit_out        <= 1'b0;
      end
      else
      begin
         modulation_out <= keyed;
         signal_out     <= plain;
         bit_out        <= data_bit;
      end
   end

   // a zero bit in BPSK must flip the carrier that was sampled
   a_bpsk_inverts: assert property (@(posedge clk) disable iff (reset)
      ($past(modulation_sel) == MOD_BPSK && !bit_out)
         |-> (modulation_out + $past(cosine) == '0));

endmodule

`default_nettype wire

/* src/dds_modulation_top.sv */
`timescale 1ns/10ps
`default_nettype none

// DDS signal generator with LFSR-keyed modulation
module dds_modulation_top
   import dds_pkg::*;
(
   input  logic    clk,
   input  logic    reset,
   input  phase_t  carrier_increment,
   input  phase_t  fsk_increment,
   input  period_t bit_period,
   input  select_t signal_sel,
   input  select_t modulation_sel,
   output sample_t signal_out,
   output sample_t modulation_out,
   output logic    data_bit
);

   logic    lfsr_bit;         // raw bit, one stage ahead of data_bit
   sample_t carrier_sine;
   sample_t carrier_cosine;
   sample_t carrier_saw;
   sample_t carrier_square;
   sample_t fsk_cosine;

   //////////////////////////////////////////////////
   // bit source and the two generators
   //////////////////////////////////////////////////
   lfsr_bit_source bit_source (
      .clk        (clk),
      .reset      (reset),
      .bit_period (bit_period),
      .data_bit   (lfsr_bit)
   );

   dds_waveform_gen carrier_gen (
      .clk             (clk),
      .reset           (reset),
      .phase_increment (carrier_increment),
      .sine            (carrier_sine),
      .cosine          (carrier_cosine),
      .saw             (carrier_saw),
      .square          (carrier_square)
   );

   // only the cosine of the shifted tone is needed
   dds_waveform_gen fsk_gen (
      .clk             (clk),
      .reset           (reset),
      .phase_increment (fsk_increment),
      .sine            (),
      .cosine          (fsk_cosine),
      .saw             (),
      .square          ()
   );

   modulation_select output_select (
      .clk            (clk),
      .reset          (reset),
      .modulation_sel (modulation_sel),
      .signal_sel     (signal_sel),
      .data_bit       (lfsr_bit),
      .sine           (carrier_sine),
      .cosine         (carrier_cosine),
      .saw            (carrier_saw),
      .square         (carrier_square),
      .fsk_cosine     (fsk_cosine),
      .modulation_out (modulation_out),
      .signal_out     (signal_out),
      .bit_out        (data_bit)       // aligned with modulation_out
   );

endmodule

`default_nettype wire

/* verif/tb_dds_modulation.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_dds_modulation
   import dds_pkg::*;
();

   // the waveform generator has already pulled the table in
   `undef DDS_SINE_TABLE_SVH
   `include "dds_sine_table.svh"

   localparam int MAX_ROWS     = 16;
   localparam int RESET_CYCLES = 16;

   logic    clk;
   logic    reset;
   phase_t  carrier_increment;
   phase_t  fsk_increment;
   period_t bit_period;
   select_t signal_sel;
   select_t modulation_sel;
   sample_t signal_out;
   sample_t modulation_out;
   logic    data_bit;

   // stimulus table columns indexed by row
   select_t row_sig    [MAX_ROWS];
   select_t row_mod    [MAX_ROWS];
   phase_t  row_car    [MAX_ROWS];
   phase_t  row_fsk    [MAX_ROWS];
   period_t row_period [MAX_ROWS];
   int      row_cycles [MAX_ROWS];
   logic    row_random [MAX_ROWS];   // draw both increments from the LCG
   int      num_rows;
   int      cycle_limit;
   int      cycle_count;
   logic [31:0] rng_state;

   // reference model registers
   phase_t  m_car_phase;
   phase_t  m_fsk_phase;
   sample_t m_sine;
   sample_t m_cos;
   sample_t m_saw;
   sample_t m_square;
   sample_t m_fsk_cos;
   period_t m_count;
   logic    m_tick;
   lfsr_t   m_lfsr;
   sample_t m_sig_out;
   sample_t m_mod_out;
   logic    m_bit_out;

   int sig_errors;
   int mod_errors;
   int bit_errors;

   dds_modulation_top DUT (
      .clk               (clk),
      .reset             (reset),
      .carrier_increment (carrier_increment),
      .fsk_increment     (fsk_increment),
      .bit_period        (bit_period),
      .signal_sel        (signal_sel),
      .modulation_sel    (modulation_sel),
      .signal_out        (signal_out),
      .modulation_out    (modulation_out),
      .data_bit          (data_bit)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;   // 8 ns period
   end

   //////////////////////////////////////////////////
   // reference waveforms
   //////////////////////////////////////////////////
   function automatic sample_t sine_at(input logic [7:0] k);
      int idx;
      int value;
      idx = k;
      if (idx < 64)
         value = sine_quarter[idx];
      else if (idx < 128)
         value = sine_quarter[127 - idx];
      else if (idx < 192)
         value = -int'(sine_quarter[idx - 128]);
      else
         value = -int'(sine_quarter[255 - idx]);
      return sample_t'(value);
   endfunction

   function automatic sample_t cosine_at(input logic [7:0] k);
      logic [7:0] shifted;
      shifted = k + 8'd64;   // quarter wave ahead with wrap
      return sine_at(shifted);
   endfunction

   function automatic sample_t keyed_sample(input select_t sel, input logic b,
                                            input sample_t cos_s, input sample_t fsk_s);
      case (sel)
         MOD_ASK:  return b ? cos_s : sample_t'(0);
         MOD_FSK:  return fsk_s;
         MOD_BPSK: return b ? cos_s : -cos_s;
         default:  return b ? SAMPLE_MAX : SAMPLE_MIN;
      endcase
   endfunction

   function automatic logic [31:0] draw_random();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   task automatic add_row(input select_t sig, input select_t md, input phase_t car,
                          input phase_t fsk, input period_t period, input int cycles,
                          input logic rnd);
      row_sig[num_rows]    = sig;
      row_mod[num_rows]    = md;
      row_car[num_rows]    = car;
      row_fsk[num_rows]    = fsk;
      row_period[num_rows] = period;
      row_cycles[num_rows] = cycles;
      row_random[num_rows] = rnd;
      num_rows++;
   endtask

   // bit periods never shrink from row to row
   task automatic load_table();
      int total;
      num_rows = 0;
      add_row(SIG_SINE,   MOD_RAW,  32'h0100_0000, 32'h0200_0000,  1,  40, 1'b0);
      add_row(SIG_COSINE, MOD_RAW,  32'h0400_0000, 32'h0200_0000,  3,  60, 1'b0);
      add_row(SIG_SAW,    MOD_ASK,  32'h0123_4567, 32'h0200_0000, 20, 120, 1'b0);
      add_row(SIG_SQUARE, MOD_BPSK, 32'h0800_0000, 32'h0200_0000, 20, 100, 1'b0);
      add_row(SIG_SINE,   MOD_FSK,  32'h0280_0000, 32'h0555_5555, 20,  80, 1'b0);
      add_row(SIG_COSINE, MOD_BPSK, 32'h0,         32'h0,         20,  80, 1'b1);
      add_row(SIG_SINE,   MOD_ASK,  32'h0,         32'h0,         20,  60, 1'b1);
      add_row(SIG_SAW,    MOD_FSK,  32'h0,         32'h0,         25,  60, 1'b1);
      add_row(SIG_SQUARE, MOD_RAW,  32'h4000_0000, 32'h0180_0000, 25,  40, 1'b0);
      // quick selector changes with the same increments so the phase runs on
      add_row(SIG_COSINE, MOD_BPSK, 32'h0300_0000, 32'h0180_0000, 25,   3, 1'b0);
      add_row(SIG_SINE,   MOD_ASK,  32'h0300_0000, 32'h0180_0000, 25,   1, 1'b0);
      add_row(SIG_SAW,    MOD_RAW,  32'h0300_0000, 32'h0180_0000, 25,   2, 1'b0);
      add_row(SIG_SQUARE, MOD_FSK,  32'h0300_0000, 32'h0180_0000, 25,   1, 1'b0);
      add_row(SIG_SINE,   MOD_BPSK, 32'h3f00_0000, 32'h0180_0000, 30,  60, 1'b0);
      total = 0;
      for (int r = 0; r < num_rows; r++)
         total += row_cycles[r];
      cycle_limit = (total * 3) / 2;
   endtask

   task automatic apply_row(input int r);
      signal_sel     = row_sig[r];
      modulation_sel = row_mod[r];
      bit_period     = row_period[r];
      if (row_random[r])
      begin
         carrier_increment = draw_random();
         fsk_increment     = draw_random();
      end
      else
      begin
         carrier_increment = row_car[r];
         fsk_increment     = row_fsk[r];
      end
   endtask

   task automatic reset_model();
      m_car_phase = '0;
      m_fsk_phase = '0;
      m_sine      = '0;
      m_cos       = '0;
      m_saw       = '0;
      m_square    = '0;
      m_fsk_cos   = '0;
      m_count     = '0;
      m_tick      = 1'b0;
      m_lfsr      = LFSR_SEED;
      m_sig_out   = '0;
      m_mod_out   = '0;
      m_bit_out   = 1'b0;
   endtask

   //////////////////////////////////////////////////
   // one clock edge of the model with the last stage first
   //////////////////////////////////////////////////
   task automatic step_model();
      logic wrap;
      case (signal_sel)
         SIG_SINE:   m_sig_out = m_sine;
         SIG_COSINE: m_sig_out = m_cos;
         SIG_SAW:    m_sig_out = m_saw;
         default:    m_sig_out = m_square;
      endcase
      m_mod_out = keyed_sample(modulation_sel, m_lfsr[0], m_cos, m_fsk_cos);
      m_bit_out = m_lfsr[0];
      m_sine    = sine_at(m_car_phase[31:24]);
      m_cos     = cosine_at(m_car_phase[31:24]);
      m_saw     = m_car_phase[31:20];
      m_square  = m_car_phase[31] ? SAMPLE_MIN : SAMPLE_MAX;
      m_fsk_cos = cosine_at(m_fsk_phase[31:24]);
      m_car_phase = m_car_phase + carrier_increment;
      m_fsk_phase = m_fsk_phase + fsk_increment;
      if (m_tick)
         m_lfsr = {m_lfsr[0] ^ m_lfsr[2], m_lfsr[4:1]};   // shift right with new msb
      wrap    = (m_count == bit_period - 1);
      m_tick  = wrap;
      m_count = wrap ? '0 : m_count + 1;
   endtask

   task automatic check_outputs();
      if (signal_out !== m_sig_out)
      begin
         sig_errors++;
         $display("mismatch at %0t: signal_out got %0d expected %0d",
                  $time, signal_out, m_sig_out);
      end
      if (modulation_out !== m_mod_out)
      begin
         mod_errors++;
         $display("mismatch at %0t: modulation_out got %0d expected %0d",
                  $time, modulation_out, m_mod_out);
      end
      if (data_bit !== m_bit_out)
      begin
         bit_errors++;
         $display("mismatch at %0t: data_bit got %0b expected %0b",
                  $time, data_bit, m_bit_out);
      end
   endtask

   // stops a run that overshoots the table length
   initial
   begin
      cycle_count = 0;
      @(negedge reset);
      while (cycle_count < cycle_limit)
      begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Test failures found");
      $finish;
   end

   initial
   begin
      sig_errors        = 0;
      mod_errors        = 0;
      bit_errors        = 0;
      rng_state         = 32'h8eb5_21a3;
      reset             = 1'b1;
      carrier_increment = '0;
      fsk_increment     = '0;
      bit_period        = 32'd1;
      signal_sel        = SIG_SINE;
      modulation_sel    = MOD_ASK;
      reset_model();
      load_table();
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      check_outputs();   // everything at 0 under reset
      reset = 1'b0;
      for (int r = 0; r < num_rows; r++)
      begin
         for (int c = 0; c < row_cycles[r]; c++)
         begin
            if (c == 0)
               apply_row(r);
            @(posedge clk);
            step_model();
            #1;
            check_outputs();
         end
      end
      $display("errors: signal_out %0d, modulation_out %0d, data_bit %0d",
               sig_errors, mod_errors, bit_errors);
      if (sig_errors + mod_errors + bit_errors == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

`default_nettype wire

/* list.f */
+incdir+src
src/dds_pkg.sv
src/lfsr_bit_source.sv
src/dds_waveform_gen.sv
src/modulation_select.sv
src/dds_modulation_top.sv
verif/tb_dds_modulation.sv
